//--- cnfg_axil_slave.sv
/*
 * AXI4-Lite slave engine
 * Accepts host writes and reads one at a time and turns them into
 * single-cycle register write and read strobes with word indices
 */
`timescale 1ns/1ps

module cnfg_axil_slave (
  input  logic                                aclk,
  input  logic                                aresetn,
  // Host port
  input  logic [cnfg_pkg::axil_addr_bits-1:0] awaddr,
  input  logic                                awvalid,
  output logic                                awready,
  input  logic [cnfg_pkg::axil_data_bits-1:0] wdata,
  input  logic [cnfg_pkg::axil_strb_bits-1:0] wstrb,
  input  logic                                wvalid,
  output logic                                wready,
  output logic [1:0]                          bresp,
  output logic                                bvalid,
  input  logic                                bready,
  input  logic [cnfg_pkg::axil_addr_bits-1:0] araddr,
  input  logic                                arvalid,
  output logic                                arready,
  output logic [cnfg_pkg::axil_data_bits-1:0] rdata,
  output logic [1:0]                          rresp,
  output logic                                rvalid,
  input  logic                                rready,
  // Register side
  output logic                                wr_en,
  output logic [cnfg_pkg::reg_idx_bits-1:0]   wr_idx,
  output logic [cnfg_pkg::axil_data_bits-1:0] wr_data,
  output logic [cnfg_pkg::axil_strb_bits-1:0] wr_strb,
  output logic                                rd_en,
  output logic [cnfg_pkg::reg_idx_bits-1:0]   rd_idx,
  input  logic [cnfg_pkg::axil_data_bits-1:0] rd_data
);

  logic aw_en; // No write response outstanding

  // ----------------------------------------
  // Write channel
  // ----------------------------------------
  assign wr_en   = awready & awvalid & wready & wvalid;
  assign wr_data = wdata;
  assign wr_strb = wstrb;
  assign bresp   = 2'b00; // OKAY

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      awready <= 1'b0;
      wready  <= 1'b0;
      aw_en   <= 1'b1;
    end else if (!awready && awvalid && wvalid && aw_en) begin
      awready <= 1'b1;
      wready  <= 1'b1;
      aw_en   <= 1'b0;
    end else begin
      awready <= 1'b0;
      wready  <= 1'b0;
      if (bready && bvalid) aw_en <= 1'b1; // Response taken, reopen
    end
  end

  // Word index of the accepted write
  always_ff @(posedge aclk) begin
    if (!awready && awvalid && wvalid && aw_en) begin
      wr_idx <= awaddr[cnfg_pkg::addr_lsb +: cnfg_pkg::reg_idx_bits];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      bvalid <= 1'b0;
    end else if (wr_en && !bvalid) begin
      bvalid <= 1'b1;
    end else if (bready) begin
      bvalid <= 1'b0;
    end
  end

  // ----------------------------------------
  // Read channel
  // ----------------------------------------
  assign rd_en = arready & arvalid & ~rvalid;
  assign rdata = rd_data; // Already registered in the register file
  assign rresp = 2'b00;

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      arready <= 1'b0;
    end else begin
      arready <= !arready && arvalid && !rvalid;
    end
  end

  always_ff @(posedge aclk) begin
    if (!arready && arvalid && !rvalid) begin
      rd_idx <= araddr[cnfg_pkg::addr_lsb +: cnfg_pkg::reg_idx_bits];
    end
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      rvalid <= 1'b0;
    end else if (rd_en) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

endmodule

//--- cnfg_pkg.sv
/*
 * Shell configuration package
 * Widths, register map indices, control and status bit positions and
 * identification words shared by the host configuration slave
 */
package cnfg_pkg;

  // ----------------------------------------
  // Host bus and register map geometry
  // ----------------------------------------
  localparam int axil_data_bits = 64;
  localparam int axil_strb_bits = axil_data_bits / 8;
  localparam int n_regs         = 64;
  localparam int addr_lsb       = $clog2(axil_strb_bits); // Byte offset within a word
  localparam int reg_idx_bits   = $clog2(n_regs);
  localparam int axil_addr_bits = addr_lsb + reg_idx_bits;

  // PR DMA request fields
  localparam int paddr_bits     = 48;
  localparam int len_bits       = 28;
  localparam int dma_req_bits   = 1 + paddr_bits + len_bits; // {ctl, paddr, len}
  localparam int pr_queue_depth = 16;

  // Network and board control widths
  localparam int ip_addr_bits      = 32;
  localparam int board_num_bits    = 4;
  localparam int lowspeed_bits     = 6;
  localparam int lowspeed_out_bits = 3;

  // ----------------------------------------
  // Register indices
  // ----------------------------------------
  localparam int probe_reg        = 0;
  localparam int n_chan_reg       = 1;
  localparam int n_regions_reg    = 2;
  localparam int pr_cnfg_reg      = 5;
  localparam int lowspeed_reg     = 8;
  localparam int pr_ctrl_reg      = 10; // Write 1 to start
  localparam int pr_stat_reg      = 11;
  localparam int pr_addr_reg      = 12;
  localparam int pr_len_reg       = 13;
  localparam int net_ipaddr_reg   = 20;
  localparam int net_boardnum_reg = 21;
  localparam int net_arp_reg      = 22;

  // PR control word bits
  localparam int pr_start = 0;
  localparam int pr_ctl   = 1;
  localparam int pr_clr   = 2;

  // PR status word bits
  localparam int pr_done  = 0;
  localparam int pr_ready = 1;

  // Identification words
  localparam logic [31:0] probe_id  = 32'h06f0_cafe;
  localparam logic [31:0] n_chan    = 32'd4;
  localparam logic [31:0] n_regions = 32'd1;
  localparam logic [31:0] pr_flow   = 32'd1;

endpackage

//--- cnfg_reg_file.sv
/*
 * Shell register file
 * Lowspeed control, PR control and status, PR address and length with
 * byte-strobe merge, and the registered read multiplexer
 */
`timescale 1ns/1ps

module cnfg_reg_file (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  input  logic                                   wr_en,
  input  logic [cnfg_pkg::reg_idx_bits-1:0]      wr_idx,
  input  logic [cnfg_pkg::axil_data_bits-1:0]    wr_data,
  input  logic [cnfg_pkg::axil_strb_bits-1:0]    wr_strb,
  input  logic                                   rd_en,
  input  logic [cnfg_pkg::reg_idx_bits-1:0]      rd_idx,
  output logic [cnfg_pkg::axil_data_bits-1:0]    rd_data,
  input  logic                                   pr_ready,    // PR queue not full
  input  logic                                   pr_dma_done,
  output logic [cnfg_pkg::lowspeed_out_bits-1:0] lowspeed_ctrl_0,
  output logic [cnfg_pkg::lowspeed_out_bits-1:0] lowspeed_ctrl_1,
  output logic                                   pr_req_valid,
  output logic                                   pr_req_ctl,
  output logic [cnfg_pkg::paddr_bits-1:0]        pr_req_paddr,
  output logic [cnfg_pkg::len_bits-1:0]          pr_req_len
);

  logic [cnfg_pkg::lowspeed_bits-1:0]  lowspeed;
  logic [15:0]                         pr_ctrl;   // Lanes 0 and 1
  logic [cnfg_pkg::axil_data_bits-1:0] pr_addr;
  logic [31:0]                         pr_len;    // Lanes 0 to 3
  logic                                done;

  // ----------------------------------------
  // Writes
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      lowspeed <= '1;
      pr_ctrl  <= '0;
      pr_addr  <= '0;
      pr_len   <= '0;
      done     <= 1'b0;
    end else begin
      pr_ctrl <= '0; // Start and clear last one cycle
      // Clear beats a done arriving in the same cycle
      if (pr_ctrl[cnfg_pkg::pr_clr]) done <= 1'b0;
      else if (pr_dma_done)          done <= 1'b1;

      if (wr_en) begin
        case (wr_idx)
          cnfg_pkg::lowspeed_reg:
            if (wr_strb[0]) lowspeed <= wr_data[cnfg_pkg::lowspeed_bits-1:0];
          cnfg_pkg::pr_ctrl_reg:
            for (int i = 0; i < 2; i++) begin
              if (wr_strb[i]) pr_ctrl[i*8 +: 8] <= wr_data[i*8 +: 8];
            end
          cnfg_pkg::pr_addr_reg:
            for (int i = 0; i < cnfg_pkg::axil_strb_bits; i++) begin
              if (wr_strb[i]) pr_addr[i*8 +: 8] <= wr_data[i*8 +: 8];
            end
          cnfg_pkg::pr_len_reg:
            for (int i = 0; i < 4; i++) begin
              if (wr_strb[i]) pr_len[i*8 +: 8] <= wr_data[i*8 +: 8];
            end
          default: ;
        endcase
      end
    end
  end

  // ----------------------------------------
  // Read multiplexer
  // ----------------------------------------
  always_ff @(posedge aclk) begin
    if (rd_en) begin
      rd_data <= '0;
      case (rd_idx)
        cnfg_pkg::probe_reg:     rd_data[31:0] <= cnfg_pkg::probe_id;
        cnfg_pkg::n_chan_reg:    rd_data[31:0] <= cnfg_pkg::n_chan;
        cnfg_pkg::n_regions_reg: rd_data[31:0] <= cnfg_pkg::n_regions;
        cnfg_pkg::pr_cnfg_reg:   rd_data[31:0] <= cnfg_pkg::pr_flow;
        cnfg_pkg::lowspeed_reg:
          rd_data[cnfg_pkg::lowspeed_bits-1:0] <= lowspeed;
        cnfg_pkg::pr_stat_reg: begin
          rd_data[cnfg_pkg::pr_ready] <= pr_ready;
          rd_data[cnfg_pkg::pr_done]  <= done;
        end
        cnfg_pkg::pr_addr_reg:   rd_data <= pr_addr;
        cnfg_pkg::pr_len_reg:    rd_data[31:0] <= pr_len;
        default: ;
      endcase
    end
  end

  // Both cages share one setting
  assign lowspeed_ctrl_0 = lowspeed[cnfg_pkg::lowspeed_out_bits-1:0];
  assign lowspeed_ctrl_1 = lowspeed[cnfg_pkg::lowspeed_out_bits-1:0];

  // PR request toward the queue
  assign pr_req_valid = pr_ctrl[cnfg_pkg::pr_start];
  assign pr_req_ctl   = pr_ctrl[cnfg_pkg::pr_ctl];
  assign pr_req_paddr = pr_addr[cnfg_pkg::paddr_bits-1:0];
  assign pr_req_len   = pr_len[cnfg_pkg::len_bits-1:0];

endmodule

//--- cnfg_slave.sv
/*
 * Host configuration slave top level
 * AXI4-Lite engine, shell register file, network port 0 settings
 * and the PR DMA request queue
 */
`timescale 1ns/1ps

module cnfg_slave (
  input  logic                                   aclk,
  input  logic                                   aresetn,
  // AXI4-Lite host port
  input  logic [cnfg_pkg::axil_addr_bits-1:0]    awaddr,
  input  logic                                   awvalid,
  output logic                                   awready,
  input  logic [cnfg_pkg::axil_data_bits-1:0]    wdata,
  input  logic [cnfg_pkg::axil_strb_bits-1:0]    wstrb,
  input  logic                                   wvalid,
  output logic                                   wready,
  output logic [1:0]                             bresp,
  output logic                                   bvalid,
  input  logic                                   bready,
  input  logic [cnfg_pkg::axil_addr_bits-1:0]    araddr,
  input  logic                                   arvalid,
  output logic                                   arready,
  output logic [cnfg_pkg::axil_data_bits-1:0]    rdata,
  output logic [1:0]                             rresp,
  output logic                                   rvalid,
  input  logic                                   rready,
  // PR DMA read requests
  output logic                                   m_pr_dma_valid,
  input  logic                                   m_pr_dma_ready,
  output logic                                   m_pr_dma_ctl,
  output logic [cnfg_pkg::paddr_bits-1:0]        m_pr_dma_paddr,
  output logic [cnfg_pkg::len_bits-1:0]          m_pr_dma_len,
  input  logic                                   pr_dma_done,
  // Network port 0
  output logic                                   set_ip_addr_valid,
  output logic [cnfg_pkg::ip_addr_bits-1:0]      set_ip_addr_data,
  output logic                                   set_board_number_valid,
  output logic [cnfg_pkg::board_num_bits-1:0]    set_board_number_data,
  output logic                                   arp_lookup_valid,
  output logic [cnfg_pkg::ip_addr_bits-1:0]      arp_lookup_data,
  input  logic                                   arp_lookup_ready,
  // Lowspeed control
  output logic [cnfg_pkg::lowspeed_out_bits-1:0] lowspeed_ctrl_0,
  output logic [cnfg_pkg::lowspeed_out_bits-1:0] lowspeed_ctrl_1
);

  logic                                wr_en;
  logic [cnfg_pkg::reg_idx_bits-1:0]   wr_idx;
  logic [cnfg_pkg::axil_data_bits-1:0] wr_data;
  logic [cnfg_pkg::axil_strb_bits-1:0] wr_strb;
  logic                                rd_en;
  logic [cnfg_pkg::reg_idx_bits-1:0]   rd_idx;
  logic [cnfg_pkg::axil_data_bits-1:0] rd_data;
  logic                                pr_req_valid;
  logic                                pr_req_ready;
  logic                                pr_req_ctl;
  logic [cnfg_pkg::paddr_bits-1:0]     pr_req_paddr;
  logic [cnfg_pkg::len_bits-1:0]       pr_req_len;

  cnfg_axil_slave axil_i (
    .aclk, .aresetn,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .wr_en, .wr_idx, .wr_data, .wr_strb, .rd_en, .rd_idx, .rd_data
  );

  cnfg_reg_file reg_file_i (
    .aclk, .aresetn,
    .wr_en, .wr_idx, .wr_data, .wr_strb, .rd_en, .rd_idx, .rd_data,
    .pr_ready (pr_req_ready),
    .pr_dma_done,
    .lowspeed_ctrl_0, .lowspeed_ctrl_1,
    .pr_req_valid, .pr_req_ctl, .pr_req_paddr, .pr_req_len
  );

  net_cnfg net_i (
    .aclk, .aresetn,
    .wr_en, .wr_idx, .wr_data, .wr_strb,
    .set_ip_addr_valid, .set_ip_addr_data,
    .set_board_number_valid, .set_board_number_data,
    .arp_lookup_valid, .arp_lookup_data, .arp_lookup_ready
  );

  // PR requests queue as {ctl, paddr, len}
  dma_req_queue #(
    .width (cnfg_pkg::dma_req_bits),
    .depth (cnfg_pkg::pr_queue_depth)
  ) pr_queue_i (
    .aclk, .aresetn,
    .in_valid  (pr_req_valid),
    .in_ready  (pr_req_ready),
    .in_data   ({pr_req_ctl, pr_req_paddr, pr_req_len}),
    .out_valid (m_pr_dma_valid),
    .out_ready (m_pr_dma_ready),
    .out_data  ({m_pr_dma_ctl, m_pr_dma_paddr, m_pr_dma_len})
  );

endmodule

//--- cnfg_slave_assertions.sv
/*
 * Protocol assertions for the configuration slave
 * Response hold, PR request stability and ARP request hold
 */
`timescale 1ns/1ps

module cnfg_slave_assertions (
  input logic                                aclk,
  input logic                                aresetn,
  input logic                                bvalid,
  input logic                                bready,
  input logic                                rvalid,
  input logic                                rready,
  input logic [cnfg_pkg::axil_data_bits-1:0] rdata,
  input logic                                m_pr_dma_valid,
  input logic                                m_pr_dma_ready,
  input logic                                m_pr_dma_ctl,
  input logic [cnfg_pkg::paddr_bits-1:0]     m_pr_dma_paddr,
  input logic [cnfg_pkg::len_bits-1:0]       m_pr_dma_len,
  input logic                                arp_lookup_valid,
  input logic                                arp_lookup_ready
);

  bvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    bvalid && !bready |=> bvalid)
    else $error("bvalid dropped before bready");

  // Read data held with the response
  rvalid_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    rvalid && !rready |=> rvalid && $stable(rdata))
    else $error("rvalid or rdata changed before rready");

  pr_req_stable: assert property (@(posedge aclk) disable iff (!aresetn)
    m_pr_dma_valid && !m_pr_dma_ready |=>
      m_pr_dma_valid && $stable({m_pr_dma_ctl, m_pr_dma_paddr, m_pr_dma_len}))
    else $error("PR request changed under back-pressure");

  arp_hold: assert property (@(posedge aclk) disable iff (!aresetn)
    arp_lookup_valid && !arp_lookup_ready |=> arp_lookup_valid)
    else $error("arp_lookup_valid dropped before arp_lookup_ready");

endmodule

bind cnfg_slave cnfg_slave_assertions assertions_i (.*);

//--- dma_req_queue.sv
/*
 * DMA request queue
 * Circular-buffer FIFO with valid/ready on both sides
 */
`timescale 1ns/1ps

module dma_req_queue #(
  parameter int width = 32,
  parameter int depth = 16
) (
  input  logic             aclk,
  input  logic             aresetn,
  input  logic             in_valid,
  output logic             in_ready,
  input  logic [width-1:0] in_data,
  output logic             out_valid,
  input  logic             out_ready,
  output logic [width-1:0] out_data
);

  localparam int ptr_bits = $clog2(depth);
  localparam int cnt_bits = $clog2(depth + 1);

  logic [width-1:0]    mem [depth];
  logic [ptr_bits-1:0] wr_ptr;
  logic [ptr_bits-1:0] rd_ptr;
  logic [cnt_bits-1:0] count;
  logic                push;
  logic                pop;

  assign in_ready  = count != cnt_bits'(depth);
  assign out_valid = count != '0;
  assign out_data  = mem[rd_ptr]; // Head entry, stable until popped
  assign push      = in_valid & in_ready;
  assign pop       = out_valid & out_ready;

  always_ff @(posedge aclk) begin
    if (push) mem[wr_ptr] <= in_data;
  end

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == ptr_bits'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      if (pop)  rd_ptr <= (rd_ptr == ptr_bits'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      if (push && !pop)      count <= count + 1'b1;
      else if (pop && !push) count <= count - 1'b1;
    end
  end

endmodule

//--- net_cnfg.sv
/*
 * Network port 0 settings
 * IP address and board number pulses, ARP lookup request held until taken
 */
`timescale 1ns/1ps

module net_cnfg (
  input  logic                                aclk,
  input  logic                                aresetn,
  input  logic                                wr_en,
  input  logic [cnfg_pkg::reg_idx_bits-1:0]   wr_idx,
  input  logic [cnfg_pkg::axil_data_bits-1:0] wr_data,
  input  logic [cnfg_pkg::axil_strb_bits-1:0] wr_strb,
  output logic                                set_ip_addr_valid,
  output logic [cnfg_pkg::ip_addr_bits-1:0]   set_ip_addr_data,
  output logic                                set_board_number_valid,
  output logic [cnfg_pkg::board_num_bits-1:0] set_board_number_data,
  output logic                                arp_lookup_valid,
  output logic [cnfg_pkg::ip_addr_bits-1:0]   arp_lookup_data,
  input  logic                                arp_lookup_ready
);

  always_ff @(posedge aclk) begin
    if (!aresetn) begin
      set_ip_addr_valid      <= 1'b0;
      set_board_number_valid <= 1'b0;
      arp_lookup_valid       <= 1'b0;
    end else begin
      set_ip_addr_valid      <= 1'b0;
      set_board_number_valid <= 1'b0;
      if (arp_lookup_ready) arp_lookup_valid <= 1'b0;

      if (wr_en) begin
        case (wr_idx)
          cnfg_pkg::net_ipaddr_reg:
            for (int i = 0; i < 4; i++) begin
              if (wr_strb[i]) begin
                set_ip_addr_data[i*8 +: 8] <= wr_data[i*8 +: 8];
                set_ip_addr_valid          <= 1'b1;
              end
            end
          cnfg_pkg::net_boardnum_reg:
            if (wr_strb[0]) begin
              set_board_number_data  <= wr_data[cnfg_pkg::board_num_bits-1:0];
              set_board_number_valid <= 1'b1;
            end
          cnfg_pkg::net_arp_reg:
            // Lookup takes the address in network byte order
            for (int i = 0; i < 4; i++) begin
              if (wr_strb[i]) begin
                arp_lookup_data[(3-i)*8 +: 8] <= wr_data[i*8 +: 8];
                arp_lookup_valid              <= 1'b1;
              end
            end
          default: ;
        endcase
      end
    end
  end

endmodule

//--- run.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f vlog.f --top-module tb_cnfg_slave -o sim_tb \
  && ./obj_dir/sim_tb > sim.log 2>&1 \
  || echo "CHECKS FAILED" >> sim.log
cat sim.log
grep -q "CHECKS FAILED" sim.log && exit 1 || exit 0

//--- tb_cnfg_slave.sv
/*
 * Testbench for the host configuration slave
 * Random AXI4-Lite traffic checked against a register, PR queue and
 * network model kept in the testbench
 */
`timescale 1ns/1ps

module tb_cnfg_slave;

  localparam int txn_budget = 600; // Host transactions over all phases
  localparam int max_cycles = txn_budget * 30 + 2000;

  logic aclk = 1'b0;
  logic aresetn;
  logic [cnfg_pkg::axil_addr_bits-1:0] awaddr, araddr;
  logic [cnfg_pkg::axil_data_bits-1:0] wdata, rdata;
  logic [cnfg_pkg::axil_strb_bits-1:0] wstrb;
  logic awvalid, awready, wvalid, wready, bvalid, bready;
  logic arvalid, arready, rvalid, rready;
  logic [1:0] bresp, rresp;
  logic m_pr_dma_valid, m_pr_dma_ctl, pr_dma_done;
  logic m_pr_dma_ready = 1'b0;
  logic [cnfg_pkg::paddr_bits-1:0] m_pr_dma_paddr;
  logic [cnfg_pkg::len_bits-1:0] m_pr_dma_len;
  logic set_ip_addr_valid, set_board_number_valid, arp_lookup_valid;
  logic arp_lookup_ready = 1'b1;
  logic [cnfg_pkg::ip_addr_bits-1:0] set_ip_addr_data, arp_lookup_data;
  logic [cnfg_pkg::board_num_bits-1:0] set_board_number_data;
  logic [cnfg_pkg::lowspeed_out_bits-1:0] lowspeed_ctrl_0, lowspeed_ctrl_1;

  int seed = 32'h2ddf;
  int n_val_err = 0;
  int n_other_err = 0;
  int cycle_cnt;
  int wr_pick [11] = '{8, 12, 13, 0, 1, 2, 5, 11, 3, 40, 63}; // Mapped, read-only, unmapped

  // ----------------------------------------
  // Model state
  // ----------------------------------------
  logic [5:0]  m_ls = 6'h3f;
  logic [63:0] m_addr = '0;
  logic [31:0] m_len = '0;
  logic        m_done = 1'b0;
  logic [31:0] m_ip, m_arp;
  logic [3:0]  m_board;
  logic [cnfg_pkg::dma_req_bits-1:0] exp_q [$];
  logic [cnfg_pkg::dma_req_bits-1:0] pr_word, head;
  int pr_seq = 0, pr_seen = 0;     // Starts written / starts taken by the model queue
  int ip_seq = 0, ip_seen = 0;
  int board_seq = 0, board_seen = 0;
  int arp_seq = 0, arp_acc = 0;    // ARP requests written / accepted
  logic pr_accept;
  logic dma_rand = 1'b0, dma_open = 1'b1, arp_rand = 1'b0;
  logic [31:0] stall_rnd;

  cnfg_slave dut_i (.*);

  always #20 aclk = ~aclk;

  function automatic logic [31:0] rand32();
    return $random(seed);
  endfunction

  function automatic logic [63:0] rand64();
    logic [31:0] hi;
    logic [31:0] lo;
    hi = rand32();
    lo = rand32();
    return {hi, lo};
  endfunction

  task automatic check_value(input string name, input logic [63:0] exp, input logic [63:0] act);
    assert (act === exp)
    else begin
      n_val_err++;
      $display("ERR %s expected %h got %h", name, exp, act);
    end
  endtask

  // Register images as the host should read them back
  function automatic logic [63:0] exp_read(input int idx);
    logic [63:0] v;
    v = '0;
    case (idx)
      cnfg_pkg::probe_reg:     v[31:0] = 32'h06f0_cafe;
      cnfg_pkg::n_chan_reg:    v[31:0] = 32'd4;
      cnfg_pkg::n_regions_reg: v[31:0] = 32'd1;
      cnfg_pkg::pr_cnfg_reg:   v[31:0] = 32'd1;
      cnfg_pkg::lowspeed_reg:  v[5:0] = m_ls;
      cnfg_pkg::pr_stat_reg:   v[1:0] = {exp_q.size() < cnfg_pkg::pr_queue_depth, m_done};
      cnfg_pkg::pr_addr_reg:   v = m_addr;
      cnfg_pkg::pr_len_reg:    v[31:0] = m_len;
      default: ;
    endcase
    return v;
  endfunction

  // Applied on the write edge
  task automatic model_write(input int idx, input logic [63:0] data, input logic [7:0] strb);
    case (idx)
      cnfg_pkg::lowspeed_reg:
        if (strb[0]) m_ls = data[5:0];
      cnfg_pkg::pr_ctrl_reg:
        if (strb[0]) begin
          if (data[2]) m_done = 1'b0;
          if (data[0]) begin
            pr_word <= {data[1], m_addr[47:0], m_len[27:0]};
            pr_seq  <= pr_seq + 1;
          end
        end
      cnfg_pkg::pr_addr_reg:
        for (int i = 0; i < 8; i++) begin
          if (strb[i]) m_addr[i*8 +: 8] = data[i*8 +: 8];
        end
      cnfg_pkg::pr_len_reg:
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) m_len[i*8 +: 8] = data[i*8 +: 8];
        end
      cnfg_pkg::net_ipaddr_reg: begin
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) m_ip[i*8 +: 8] = data[i*8 +: 8];
        end
        if (strb[3:0] != 4'h0) ip_seq <= ip_seq + 1;
      end
      cnfg_pkg::net_boardnum_reg:
        if (strb[0]) begin
          m_board = data[3:0];
          board_seq <= board_seq + 1;
        end
      cnfg_pkg::net_arp_reg: begin
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) m_arp[(3-i)*8 +: 8] = data[i*8 +: 8]; // Network byte order
        end
        if (strb[3:0] != 4'h0) arp_seq <= arp_seq + 1;
      end
      default: ;
    endcase
  endtask

  // ----------------------------------------
  // Host bus tasks
  // ----------------------------------------
  task automatic host_write(input int idx, input logic [63:0] data, input logic [7:0] strb,
                            input logic done_same);
    logic [31:0] r;
    awaddr  <= {6'(idx), 3'b000};
    awvalid <= 1'b1;
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    do @(posedge aclk); while (!(awready && wready));
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    model_write(idx, data, strb);
    if (done_same) pr_dma_done <= 1'b1; // Lands with the clear strobe
    @(posedge aclk);
    pr_dma_done <= 1'b0;
    r = rand32();
    repeat (r[1:0]) @(posedge aclk);
    bready <= 1'b1;
    do @(posedge aclk); while (!bvalid);
    check_value("bresp", 64'h0, 64'(bresp));
    bready <= 1'b0;
  endtask

  task automatic read_check(input int idx);
    logic [31:0] r;
    logic [63:0] d;
    araddr  <= {6'(idx), 3'b000};
    arvalid <= 1'b1;
    do @(posedge aclk); while (!arready);
    arvalid <= 1'b0;
    r = rand32();
    repeat (r[1:0]) @(posedge aclk);
    rready <= 1'b1;
    do @(posedge aclk); while (!rvalid);
    d = rdata;
    check_value("rresp", 64'h0, 64'(rresp));
    check_value($sformatf("rdata (reg %0d)", idx), exp_read(idx), d);
    rready <= 1'b0;
  endtask

  task automatic start_pr();
    logic [31:0] r;
    r = rand32();
    if (r[0]) host_write(cnfg_pkg::pr_addr_reg, rand64(), r[15:8], 1'b0);
    if (r[1]) host_write(cnfg_pkg::pr_len_reg, rand64(), r[23:16], 1'b0);
    host_write(cnfg_pkg::pr_ctrl_reg, {62'h0, r[2], 1'b1}, 8'h01, 1'b0);
  endtask

  task automatic pulse_done();
    pr_dma_done <= 1'b1;
    @(posedge aclk);
    pr_dma_done <= 1'b0;
    m_done = 1'b1;
  endtask

  // Sink stalls
  always @(posedge aclk) begin
    stall_rnd = rand32();
    m_pr_dma_ready   <= dma_rand ? stall_rnd[0] : dma_open;
    arp_lookup_ready <= arp_rand ? stall_rnd[1] : 1'b1;
  end

  // ----------------------------------------
  // Output monitor
  // ----------------------------------------
  always @(posedge aclk) begin
    if (aresetn) begin
      pr_accept = exp_q.size() < cnfg_pkg::pr_queue_depth; // Full queue drops the start
      check_value("m_pr_dma_valid", 64'(exp_q.size() != 0), 64'(m_pr_dma_valid));
      if (m_pr_dma_valid && m_pr_dma_ready) begin
        assert (exp_q.size() != 0)
        else begin
          n_other_err++;
          $display("PR request left the queue when none was expected");
        end
        if (exp_q.size() != 0) begin
          head = exp_q.pop_front();
          check_value("m_pr_dma_ctl", 64'(head[76]), 64'(m_pr_dma_ctl));
          check_value("m_pr_dma_paddr", 64'(head[75:28]), 64'(m_pr_dma_paddr));
          check_value("m_pr_dma_len", 64'(head[27:0]), 64'(m_pr_dma_len));
        end
      end
      if (pr_seq != pr_seen) begin
        if (pr_accept) exp_q.push_back(pr_word);
        pr_seen <= pr_seq;
      end

      check_value("set_ip_addr_valid", 64'(ip_seq != ip_seen), 64'(set_ip_addr_valid));
      if (ip_seq != ip_seen) begin
        check_value("set_ip_addr_data", 64'(m_ip), 64'(set_ip_addr_data));
        ip_seen <= ip_seq;
      end
      check_value("set_board_number_valid", 64'(board_seq != board_seen),
                  64'(set_board_number_valid));
      if (board_seq != board_seen) begin
        check_value("set_board_number_data", 64'(m_board), 64'(set_board_number_data));
        board_seen <= board_seq;
      end
      check_value("arp_lookup_valid", 64'(arp_seq != arp_acc), 64'(arp_lookup_valid));
      if (arp_seq != arp_acc) begin
        check_value("arp_lookup_data", 64'(m_arp), 64'(arp_lookup_data));
        if (arp_lookup_ready) arp_acc <= arp_seq;
      end
    end
  end

  initial begin : watchdog
    cycle_cnt = 0;
    while (cycle_cnt < max_cycles) begin
      @(posedge aclk);
      cycle_cnt++;
    end
    $display("Timeout after %0d cycles, test sequence did not finish", cycle_cnt);
    $display("CHECKS FAILED");
    $finish;
  end

  // ----------------------------------------
  // Stimulus
  // ----------------------------------------
  initial begin : stimulus
    logic [31:0] r;
    aresetn <= 1'b0;
    awaddr  <= '0;
    awvalid <= 1'b0;
    wdata   <= '0;
    wstrb   <= '0;
    wvalid  <= 1'b0;
    bready  <= 1'b0;
    araddr  <= '0;
    arvalid <= 1'b0;
    rready  <= 1'b0;
    pr_dma_done <= 1'b0;
    repeat (16) @(posedge aclk);
    aresetn <= 1'b1;
    @(posedge aclk);

    // Reset state
    check_value("{awready,wready,arready,bvalid,rvalid}", 64'h0,
                64'({awready, wready, arready, bvalid, rvalid}));
    check_value("lowspeed_ctrl_0", 64'h7, 64'(lowspeed_ctrl_0));
    check_value("lowspeed_ctrl_1", 64'h7, 64'(lowspeed_ctrl_1));
    foreach (wr_pick[k]) read_check(wr_pick[k]);

    // Random writes, then read-back of a random word
    for (int n = 0; n < 150; n++) begin
      r = rand32();
      host_write(wr_pick[r % 11], rand64(), r[15:8], 1'b0);
      read_check(wr_pick[rand32() % 11]);
      check_value("lowspeed_ctrl_0", 64'(m_ls[2:0]), 64'(lowspeed_ctrl_0));
      check_value("lowspeed_ctrl_1", 64'(m_ls[2:0]), 64'(lowspeed_ctrl_1));
    end

    // PR starts, first against a stalled sink to fill the queue
    dma_open <= 1'b0;
    for (int n = 0; n < 18; n++) start_pr();
    read_check(cnfg_pkg::pr_stat_reg);
    dma_rand <= 1'b1;
    for (int n = 0; n < 20; n++) start_pr();
    dma_rand <= 1'b0;
    dma_open <= 1'b1;
    while (exp_q.size() != 0) @(posedge aclk);
    read_check(cnfg_pkg::pr_stat_reg);

    // Sticky done and clear
    pulse_done();
    read_check(cnfg_pkg::pr_stat_reg);
    read_check(cnfg_pkg::pr_stat_reg);
    host_write(cnfg_pkg::pr_ctrl_reg, 64'h4, 8'h01, 1'b0);
    read_check(cnfg_pkg::pr_stat_reg);
    pulse_done();
    read_check(cnfg_pkg::pr_stat_reg);
    host_write(cnfg_pkg::pr_ctrl_reg, 64'h4, 8'h01, 1'b1);
    read_check(cnfg_pkg::pr_stat_reg);

    // IP address and board number
    for (int n = 0; n < 10; n++) begin
      r = rand32();
      host_write(cnfg_pkg::net_ipaddr_reg, rand64(), (n == 0) ? 8'hff : r[7:0], 1'b0);
      host_write(cnfg_pkg::net_boardnum_reg, rand64(), r[15:8], 1'b0);
    end

    // ARP lookups against a stalling receiver
    arp_rand <= 1'b1;
    for (int n = 0; n < 12; n++) begin
      while (arp_seq != arp_acc) @(posedge aclk);
      r = rand32();
      host_write(cnfg_pkg::net_arp_reg, rand64(), (n == 0) ? 8'hff : r[7:0], 1'b0);
    end
    while (arp_seq != arp_acc) @(posedge aclk);
    arp_rand <= 1'b0;

    repeat (4) @(posedge aclk);
    $display("Error counts: %0d value, %0d other", n_val_err, n_other_err);
    if (n_val_err == 0 && n_other_err == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
cnfg_pkg.sv
cnfg_axil_slave.sv
cnfg_reg_file.sv
net_cnfg.sv
dma_req_queue.sv
cnfg_slave.sv
cnfg_slave_assertions.sv
tb_cnfg_slave.sv
